//--- files.f
rtl/plot_cmd_pkg.sv
rtl/geo_pkg.sv
rtl/cmd_fifo.sv
rtl/coord_regs.sv
rtl/plot_sequencer.sv
rtl/rect_engine.sv
rtl/geometry_plotter.sv
tb/tb_geometry_plotter.sv

//--- Makefile
# Verilator build and run of the geometry plotter testbench
TOP       ?= tb_geometry_plotter
SEED      ?= 87a667ce
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat files.f)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): files.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=32\'h$(SEED) \
		-f files.f --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_geometry_plotter.sv
`timescale 1ns/10ps

module tb_geometry_plotter;

  parameter logic [31:0] SEED = 32'h87a6_67ce;
  localparam int FIFO_DEPTH  = 16;
  localparam int FIFO_MARGIN = 4;
  localparam int TMO         = 20000;              // cycles allowed per wait

  logic                     clk;
  logic                     reset;
  logic                     host_wr;
  plot_cmd_pkg::host_word_t host_word;
  logic                     draw_busy;
  logic                     fifo_cmd_busy;
  logic                     load_cmd;
  logic                     draw_cmd_rdy;
  plot_cmd_pkg::draw_cmd_t  draw_cmd;

  logic [35:0] exp_q[$];                           // expected draw commands in order
  int          mx[4];                              // mirror of x[0..3]
  int          my[4];                              // mirror of y[0..3]
  int          win_x, win_y;                       // mirror of the clip window
  int          fifo_cnt;                           // model FIFO fill
  int          errors, extras;
  logic        busy_prev;                          // draw_busy one cycle back
  logic        busy_en;                            // random pixel-side stalls on

  geometry_plotter #(.FIFO_DEPTH(FIFO_DEPTH), .FIFO_MARGIN(FIFO_MARGIN)) dut0 (
    .clk(clk), .reset(reset), .host_wr(host_wr), .host_word(host_word),
    .draw_busy(draw_busy), .fifo_cmd_busy(fifo_cmd_busy), .load_cmd(load_cmd),
    .draw_cmd_rdy(draw_cmd_rdy), .draw_cmd(draw_cmd)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;                           // 20 ns period

  always @(posedge clk) begin
    if (busy_en) draw_busy <= ($urandom_range(3, 0) == 0);
    else draw_busy <= 1'b0;
  end

  task automatic check(input string what, input logic [35:0] got, input logic [35:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("timeout at %0t: %s", $time, why);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  function automatic logic [35:0] cmd(input logic [3:0] f, input logic [7:0] c,
                                      input int wy, input int wx);
    return {f, c, 12'(wy), 12'(wx)};
  endfunction

  function automatic logic [15:0] xwr(input int n, input int v);
    return {2'b10, 2'(n), 12'(v)};
  endfunction

  function automatic logic [15:0] ywr(input int n, input int v);
    return {2'b11, 2'(n), 12'(v)};
  endfunction

  function automatic logic [7:0] rnd8();
    return 8'($urandom_range(255, 0));
  endfunction

  function automatic logic [15:0] odd_shape();
    int sh;
    sh = $urandom_range(6, 0);
    if (sh >= 2) sh++;                             // anything but a rectangle
    return {3'b000, 2'($urandom_range(3, 0)), 3'(sh), rnd8()};
  endfunction

  function automatic logic [15:0] random_word();
    case ($urandom_range(7, 0))
      0: return xwr($urandom_range(3, 0), $urandom_range(15, 0));
      1: return ywr($urandom_range(3, 0), $urandom_range(15, 0));
      2: return {5'b01111, 3'($urandom_range(7, 0)), rnd8()};    // 0x78..0x7F
      3: return {6'b011100, 2'($urandom_range(3, 0)), rnd8()};   // raster widths
      4: return {6'b010111, 2'($urandom_range(3, 0)), rnd8()};   // clip window
      5: return {7'b0101101, 1'($urandom_range(1, 0)), rnd8()};  // mask resets
      6: return {3'b000, 2'($urandom_range(3, 0)), 3'd2, rnd8()};
      default: return odd_shape();
    endcase
  endfunction

  // ******************************
  // reference model
  // ******************************
  task automatic model_rect(input logic fill, input logic [7:0] c);
    int x, y, sx, sy;
    sx = (mx[1] > mx[0]) ? 1 : (mx[1] < mx[0]) ? -1 : 0;
    sy = (my[1] > my[0]) ? 1 : (my[1] < my[0]) ? -1 : 0;
    y  = my[0];
    forever begin
      x = mx[0];
      forever begin
        if (x <= win_x && y <= win_y) exp_q.push_back(cmd(4'd1, c, y, x));
        if (x == mx[1]) break;
        if (fill || y == my[0] || y == my[1]) x += sx;
        else x = mx[1];                            // outline row jumps to the right edge
      end
      if (y == my[1]) break;
      y += sy;
    end
  endtask

  task automatic model_word(input logic [15:0] w);
    logic [7:0] op;
    logic [7:0] d8;
    int         k;
    op = w[15:8];
    d8 = w[7:0];
    k  = int'(op[1:0]);
    if (op >= 8'hC0) my[op[5:4]] = int'(w[11:0]);
    else if (op >= 8'h80) mx[op[5:4]] = int'(w[11:0]);
    else if (op >= 8'h7C) exp_q.push_back(cmd(4'd14, d8, my[k], mx[k]));
    else if (op >= 8'h78) exp_q.push_back(cmd(4'd15, d8, my[k], mx[k]));
    else if (op == 8'h73) exp_q.push_back(cmd(4'd12, d8, my[2], mx[2]));
    else if (op == 8'h71) exp_q.push_back(cmd(4'd12, d8, my[3], mx[3]));
    else if (op == 8'h72) exp_q.push_back(cmd(4'd13, d8, my[2], mx[2]));
    else if (op == 8'h70) exp_q.push_back(cmd(4'd13, d8, my[3], mx[3]));
    else if (op >= 8'h5C && op <= 8'h5F) begin
      win_x = mx[3 - k];                           // 0x5F takes point 0
      win_y = my[3 - k];
    end
    else if (op == 8'h5B || op == 8'h5A)
      exp_q.push_back(cmd(op[0] ? 4'd10 : 4'd11, d8, {d8, d8[7:4]}, {d8[3:0], d8[7:4]}));
    else if (op <= 8'h1F && op[2:0] == 3'd2) model_rect(op[3], d8);
  endtask

  // ******************************
  // host side and output checker
  // ******************************
  task automatic send_word(input logic [15:0] w);
    int t;
    t = 0;
    @(posedge clk);
    while (fifo_cmd_busy && t < TMO) begin
      host_wr <= 1'b0;                             // hold off while the FIFO is busy
      t++;
      @(posedge clk);
    end
    host_wr   <= 1'b1;
    host_word <= w;
    model_word(w);
    if (t >= TMO) abort_run("fifo_cmd_busy never cleared");
  endtask

  task automatic end_burst();
    @(posedge clk);
    host_wr <= 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!(exp_q.size() == 0 && fifo_cnt == 0 && load_cmd) && t < TMO);
    if (t >= TMO) abort_run({what, " did not drain"});
  endtask

  always @(posedge clk) begin
    if (reset) begin
      fifo_cnt  <= 0;
      busy_prev <= 1'b0;
    end else begin
      check("fifo_cmd_busy", {35'd0, fifo_cmd_busy},
            {35'd0, fifo_cnt >= FIFO_DEPTH - FIFO_MARGIN});
      check("draw_cmd_rdy after draw_busy", {35'd0, draw_cmd_rdy & busy_prev}, 36'd0);
      if (draw_cmd_rdy) begin
        if (exp_q.size() == 0) begin
          extras++;
          $display("unexpected draw command %h at %0t", draw_cmd, $time);
        end else check("draw_cmd", draw_cmd, exp_q.pop_front());
      end
      fifo_cnt  <= fifo_cnt + int'(host_wr) - int'(fifo_cnt > 0 && load_cmd && !draw_busy);
      busy_prev <= draw_busy;
    end
  end

  initial begin
    int i;
    void'($urandom(SEED));
    errors = 0;
    extras = 0;
    reset = 1'b1;
    host_wr = 1'b0;
    host_word = '0;
    draw_busy = 1'b0;
    busy_en = 1'b0;
    for (i = 0; i < 4; i++) begin
      mx[i] = 0;
      my[i] = 0;
    end
    win_x = 0;
    win_y = 0;
    repeat (8) @(posedge clk);
    check("load_cmd in reset", {35'd0, load_cmd}, 36'd1);
    check("draw_cmd_rdy in reset", {35'd0, draw_cmd_rdy | fifo_cmd_busy}, 36'd0);
    reset <= 1'b0;

    repeat (6) begin                               // coordinates and base addresses
      for (i = 0; i < 4; i++) begin
        send_word(xwr(i, $urandom_range(4095, 0)));
        send_word(ywr(i, $urandom_range(4095, 0)));
      end
      send_word({6'b011111, 2'($urandom_range(3, 0)), rnd8()});
      send_word({6'b011110, 2'($urandom_range(3, 0)), rnd8()});
    end
    for (i = 0; i < 4; i++) begin                  // raster widths and silent clip writes
      send_word({6'b011100, 2'(i), rnd8()});
      send_word({6'b010111, 2'(i), rnd8()});
    end
    repeat (8) send_word({7'b0101101, 1'($urandom_range(1, 0)), rnd8()});
    end_burst();
    wait_drain("setup commands");

    for (i = 0; i < 20; i++) begin                 // filled rectangles first then outline
      send_word(xwr(3, $urandom_range(15, 4)));
      send_word(ywr(3, $urandom_range(15, 4)));
      send_word({8'h5C, rnd8()});                  // window from point 3
      send_word(xwr(0, $urandom_range(15, 0)));
      send_word(ywr(0, $urandom_range(15, 0)));
      send_word(xwr(1, $urandom_range(15, 0)));
      send_word(ywr(1, $urandom_range(15, 0)));
      send_word({3'b000, 1'($urandom_range(1, 0)), (i < 10), 3'd2, rnd8()});
      if (i >= 10) send_word(odd_shape());
    end
    end_burst();
    wait_drain("rectangles");

    busy_en <= 1'b1;                               // stalls plus host bursts
    repeat (200) begin
      repeat ($urandom_range(12, 1)) send_word(random_word());
      end_burst();
      repeat ($urandom_range(5, 0)) @(posedge clk);
    end
    wait_drain("back-pressure run");
    busy_en <= 1'b0;
    repeat (4) @(posedge clk);

    $display("checks done: %0d value errors, %0d unexpected commands, %0d missing",
             errors, extras, exp_q.size());
    if (errors == 0 && extras == 0 && exp_q.size() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- rtl/geometry_plotter.sv
`timescale 1ns/10ps

module geometry_plotter #(
  parameter int FIFO_DEPTH  = 16,
  parameter int FIFO_MARGIN = 4
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     host_wr,
  input  plot_cmd_pkg::host_word_t host_word,
  input  logic                     draw_busy,
  output logic                     fifo_cmd_busy,
  output logic                     load_cmd,
  output logic                     draw_cmd_rdy,
  output plot_cmd_pkg::draw_cmd_t  draw_cmd
);

  plot_cmd_pkg::host_word_t               head;
  logic                                   not_empty, pop;
  geo_pkg::point_t [geo_pkg::N_POINTS-1:0] pts;
  geo_pkg::clip_t                         clip;
  logic                                   rect_req, rect_fill, rect_ack;
  logic                                   pix_valid;
  geo_pkg::point_t                        pix;

  // ******************************
  // host command queue
  // ******************************
  cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .FIFO_MARGIN(FIFO_MARGIN)) fifo0 (
    .clk(clk), .reset(reset), .wr(host_wr), .wdata(host_word), .pop(pop),
    .head(head), .not_empty(not_empty), .almost_full(fifo_cmd_busy)
  );

  coord_regs regs0 (
    .clk(clk), .reset(reset), .load(pop), .word(head), .pts(pts), .clip(clip)
  );

  plot_sequencer seq0 (
    .clk(clk), .reset(reset), .head(head), .not_empty(not_empty),
    .draw_busy(draw_busy), .pts(pts), .pop(pop), .load_cmd(load_cmd),
    .rect_req(rect_req), .rect_fill(rect_fill), .rect_ack(rect_ack),
    .pix_valid(pix_valid), .pix(pix), .draw_cmd_rdy(draw_cmd_rdy), .draw_cmd(draw_cmd)
  );

  rect_engine rect0 (
    .clk(clk), .reset(reset), .rect_req(rect_req), .rect_fill(rect_fill),
    .rect_ack(rect_ack), .p0(pts[0]), .p1(pts[1]), .clip(clip),
    .draw_busy(draw_busy), .pix_valid(pix_valid), .pix(pix)
  );

endmodule

//--- rtl/rect_engine.sv
`timescale 1ns/10ps

module rect_engine (
  input  logic            clk,
  input  logic            reset,
  input  logic            rect_req,
  input  logic            rect_fill,
  output logic            rect_ack,
  input  geo_pkg::point_t p0,
  input  geo_pkg::point_t p1,
  input  geo_pkg::clip_t  clip,
  input  logic            draw_busy,
  output logic            pix_valid,
  output geo_pkg::point_t pix
);

  typedef enum logic [1:0] {E_IDLE, E_RUN, E_ACK} estate_e;

  estate_e         state;
  geo_pkg::point_t cur;                         // current pen position
  geo_pkg::point_t start_pt, end_pt;            // latched corners
  geo_pkg::coord_t step_x, step_y;              // 1, 0 or -1 modulo 4096
  logic            fill_q;
  logic            in_win;
  logic            row_end, last_row, edge_row;

  assign in_win    = (cur.x <= clip.max_x) && (cur.y <= clip.max_y);
  assign pix_valid = (state == E_RUN) && in_win;  // clipped points never offered
  assign pix       = cur;
  assign rect_ack  = (state == E_ACK);
  assign row_end   = (cur.x == end_pt.x);
  assign last_row  = (cur.y == end_pt.y);
  assign edge_row  = (cur.y == start_pt.y) || last_row;

  // ******************************
  // row-by-row walk
  // ******************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= E_IDLE;
      cur      <= '0;
      start_pt <= '0;
      end_pt   <= '0;
      step_x   <= '0;
      step_y   <= '0;
      fill_q   <= 1'b0;
    end else begin
      case (state)
        E_IDLE: if (rect_req) begin
          cur      <= p0;
          start_pt <= p0;
          end_pt   <= p1;
          fill_q   <= rect_fill;
          step_x   <= (p1.x > p0.x) ? 12'd1 : (p1.x < p0.x) ? 12'hFFF : 12'd0;
          step_y   <= (p1.y > p0.y) ? 12'd1 : (p1.y < p0.y) ? 12'hFFF : 12'd0;
          state    <= E_RUN;
        end
        E_RUN: if (!draw_busy) begin                 // hold position while paused
          if (row_end) begin
            if (last_row) state <= E_ACK;            // final pixel consumed
            else begin
              cur.x <= start_pt.x;                   // back to row start
              cur.y <= cur.y + step_y;
            end
          end else if (fill_q || edge_row) begin
            cur.x <= cur.x + step_x;
          end else begin
            cur.x <= end_pt.x;                       // outline, skip the interior
          end
        end
        E_ACK:   if (!rect_req) state <= E_IDLE;   // wait for req to drop
        default: state <= E_IDLE;
      endcase
    end
  end

  // done is only signalled inside an open request
  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(rect_ack) |-> rect_req);

endmodule

//--- rtl/plot_sequencer.sv
`timescale 1ns/10ps

module plot_sequencer (
  input  logic                                    clk,
  input  logic                                    reset,
  input  plot_cmd_pkg::host_word_t                head,
  input  logic                                    not_empty,
  input  logic                                    draw_busy,
  input  geo_pkg::point_t [geo_pkg::N_POINTS-1:0] pts,
  output logic                                    pop,
  output logic                                    load_cmd,
  output logic                                    rect_req,
  output logic                                    rect_fill,
  input  logic                                    rect_ack,
  input  logic                                    pix_valid,
  input  geo_pkg::point_t                         pix,
  output logic                                    draw_cmd_rdy,
  output plot_cmd_pkg::draw_cmd_t                 draw_cmd
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_DROP} state_e;

  state_e                  state;
  logic [7:0]              pen_color;
  logic                    fill_q;
  logic                    send;
  logic                    start_rect;
  plot_cmd_pkg::draw_cmd_t nxt_cmd;
  geo_pkg::point_t         sel_pt;
  logic [7:0]              d8;

  assign load_cmd  = (state == S_IDLE);
  assign rect_req  = (state == S_REQ);
  assign rect_fill = fill_q;
  assign pop       = not_empty && load_cmd && !draw_busy;
  assign sel_pt    = pts[head.opcode[1:0]];     // point for address setup
  assign d8        = head.data8;

  // ******************************
  // command decode
  // ******************************
  always_comb begin
    send       = 1'b0;
    start_rect = 1'b0;
    nxt_cmd    = draw_cmd;
    if (pop) begin
      send = 1'b1;                                                // cleared below if no output
      case (head.opcode) inside
        [plot_cmd_pkg::OP_DSTMADDR : plot_cmd_pkg::OP_DSTMADDR + 8'd3]:
          nxt_cmd = {plot_cmd_pkg::DSTMADDR, d8, sel_pt.y, sel_pt.x};
        [plot_cmd_pkg::OP_SRCMADDR : plot_cmd_pkg::OP_SRCMADDR + 8'd3]:
          nxt_cmd = {plot_cmd_pkg::SRCMADDR, d8, sel_pt.y, sel_pt.x};
        plot_cmd_pkg::OP_DSTRW_P2: nxt_cmd = {plot_cmd_pkg::DSTRWDTH, d8, pts[2].y, pts[2].x};
        plot_cmd_pkg::OP_DSTRW_P3: nxt_cmd = {plot_cmd_pkg::DSTRWDTH, d8, pts[3].y, pts[3].x};
        plot_cmd_pkg::OP_SRCRW_P2: nxt_cmd = {plot_cmd_pkg::SRCRWDTH, d8, pts[2].y, pts[2].x};
        plot_cmd_pkg::OP_SRCRW_P3: nxt_cmd = {plot_cmd_pkg::SRCRWDTH, d8, pts[3].y, pts[3].x};
        plot_cmd_pkg::OP_RST_PXWRI_M:                               // mask colour spread
          nxt_cmd = {plot_cmd_pkg::RST_PXWRI_M, d8, d8, d8[7:4], 4'h0, d8[3:0], d8[7:4]};
        plot_cmd_pkg::OP_RST_PXPASTE_M:
          nxt_cmd = {plot_cmd_pkg::RST_PXPASTE_M, d8, d8, d8[7:4], 4'h0, d8[3:0], d8[7:4]};
        [8'h00 : plot_cmd_pkg::OP_DRAW_LAST]: begin
          send       = 1'b0;
          start_rect = (head.opcode[2:0] == plot_cmd_pkg::SHAPE_RECT);  // other shapes dropped
        end
        default: send = 1'b0;                                       // coord, clip, unused
      endcase
    end else if (pix_valid && !draw_busy) begin
      send    = 1'b1;                                               // engine pixel taken
      nxt_cmd = {plot_cmd_pkg::PXWRI, pen_color, pix.y, pix.x};
    end
  end

  // ******************************
  // four-phase start of the rectangle engine
  // ******************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= S_IDLE;
      pen_color    <= '0;
      fill_q       <= 1'b0;
      draw_cmd_rdy <= 1'b0;
    end else begin
      draw_cmd_rdy <= send;                     // one-cycle pulse
      case (state)
        S_IDLE: if (start_rect) begin
          pen_color <= d8;
          fill_q    <= head.opcode[plot_cmd_pkg::FILL_BIT];
          state     <= S_REQ;
        end
        S_REQ:   if (rect_ack) state <= S_DROP;   // last row done
        S_DROP:  if (!rect_ack) state <= S_IDLE;  // handshake closed
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (send) draw_cmd <= nxt_cmd;              // held between pulses
  end

  // a paused pixel writer never sees a pulse
  a_busy_pause: assert property (@(posedge clk) disable iff (reset)
    draw_busy |=> !draw_cmd_rdy);

endmodule

//--- rtl/coord_regs.sv
`timescale 1ns/10ps

module coord_regs (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic                                       load,   // word popped this cycle
  input  plot_cmd_pkg::host_word_t                   word,
  output geo_pkg::point_t [geo_pkg::N_POINTS-1:0]    pts,
  output geo_pkg::clip_t                             clip
);

  logic [7:0]  op;
  logic [11:0] d12;
  logic [1:0]  clip_sel;
  logic        is_clip;

  assign op       = word.opcode;
  assign d12      = plot_cmd_pkg::data12(word);
  assign clip_sel = ~op[1:0];                   // 0x5F -> point 0, 0x5C -> point 3
  assign is_clip  = (op >= plot_cmd_pkg::OP_CLIP_BASE) &&
                    (op <= plot_cmd_pkg::OP_CLIP_BASE + 8'd3);

  // ******************************
  // coordinate and window registers
  // ******************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pts  <= '0;
      clip <= '0;
    end else if (load) begin
      if (op >= plot_cmd_pkg::OP_YWR_BASE) begin
        pts[op[5:4]].y <= d12;                  // y[n] write
      end else if (op >= plot_cmd_pkg::OP_XWR_BASE) begin
        pts[op[5:4]].x <= d12;                  // x[n] write
      end else if (is_clip) begin
        clip.max_x <= pts[clip_sel].x;          // window taken from a stored point
        clip.max_y <= pts[clip_sel].y;
      end
    end
  end

endmodule

//--- rtl/cmd_fifo.sv
`timescale 1ns/10ps

module cmd_fifo #(
  parameter int FIFO_DEPTH  = 16,
  parameter int FIFO_MARGIN = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    wr,
  input  plot_cmd_pkg::host_word_t wdata,
  input  logic                    pop,
  output plot_cmd_pkg::host_word_t head,
  output logic                    not_empty,
  output logic                    almost_full
);

  localparam int AW = $clog2(FIFO_DEPTH);       // pointer width
  localparam int CW = $clog2(FIFO_DEPTH + 1);   // count width, holds DEPTH

  plot_cmd_pkg::host_word_t mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr, rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          wr_ok, rd_ok;

  assign full        = (count == CW'(FIFO_DEPTH));
  assign not_empty   = (count != '0);
  assign wr_ok       = wr && !full;             // overflow guard, extra word dropped
  assign rd_ok       = pop && not_empty;        // underflow guard
  assign head        = mem[rd_ptr];             // show-ahead
  assign almost_full = (count >= CW'(FIFO_DEPTH - FIFO_MARGIN));

  always_ff @(posedge clk) begin
    if (wr_ok) mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (wr_ok && !rd_ok)      count <= count + 1'b1;
      else if (rd_ok && !wr_ok) count <= count - 1'b1;
    end
  end

  // host must respect the busy flag margin
  a_no_overflow: assert property (@(posedge clk) disable iff (reset) wr |-> !full);
  // sequencer pops only a visible head word
  a_no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> not_empty);

endmodule

//--- rtl/geo_pkg.sv
package geo_pkg;

  localparam int N_POINTS = 4;                // x[0..3] / y[0..3]

  typedef logic [11:0] coord_t;               // unsigned screen coordinate

  typedef struct packed {
    coord_t x;
    coord_t y;
  } point_t;

  // inclusive upper bounds, lower bound is always 0
  typedef struct packed {
    coord_t max_x;
    coord_t max_y;
  } clip_t;

endpackage

//--- rtl/plot_cmd_pkg.sv
package plot_cmd_pkg;

  // ******************************
  // host command word
  // ******************************
  typedef struct packed {
    logic [7:0] opcode;                       // upper byte selects the command
    logic [7:0] data8;                        // colour, mode or mask byte
  } host_word_t;

  // lower 12 bits carry a coordinate
  function automatic logic [11:0] data12(host_word_t w);
    return {w.opcode[3:0], w.data8};
  endfunction

  // opcode range bases
  localparam logic [7:0] OP_DRAW_LAST     = 8'h1F;  // 0x00..0x1F start a shape
  localparam logic [7:0] OP_RST_PXPASTE_M = 8'h5A;
  localparam logic [7:0] OP_RST_PXWRI_M   = 8'h5B;
  localparam logic [7:0] OP_CLIP_BASE     = 8'h5C;  // 0x5C..0x5F set clip window
  localparam logic [7:0] OP_SRCRW_P3      = 8'h70;
  localparam logic [7:0] OP_DSTRW_P3      = 8'h71;
  localparam logic [7:0] OP_SRCRW_P2      = 8'h72;
  localparam logic [7:0] OP_DSTRW_P2      = 8'h73;
  localparam logic [7:0] OP_SRCMADDR      = 8'h78;  // 0x78..0x7B
  localparam logic [7:0] OP_DSTMADDR      = 8'h7C;  // 0x7C..0x7F
  localparam logic [7:0] OP_XWR_BASE      = 8'h80;  // 0x80..0xBF write x[n]
  localparam logic [7:0] OP_YWR_BASE      = 8'hC0;  // 0xC0..0xFF write y[n]

  localparam logic [2:0] SHAPE_RECT = 3'd2;   // shape field, opcode bits 2:0
  localparam int         FILL_BIT   = 3;      // fill enable in draw opcodes

  // ******************************
  // pixel writer command
  // ******************************
  typedef enum logic [3:0] {
    PXWRI         = 4'd1,
    RST_PXWRI_M   = 4'd10,
    RST_PXPASTE_M = 4'd11,
    DSTRWDTH      = 4'd12,
    SRCRWDTH      = 4'd13,
    DSTMADDR      = 4'd14,
    SRCMADDR      = 4'd15
  } draw_func_e;

  typedef struct packed {
    draw_func_e  func;                        // bits 35:32
    logic [7:0]  color;                       // bits 31:24
    logic [11:0] word_y;                      // bits 23:12
    logic [11:0] word_x;                      // bits 11:0
  } draw_cmd_t;

endpackage
